// ==== rtl/sifhPkg.sv ====
`default_nettype none

package sifhPkg;

    // sample and counter widths
    localparam int sampleW = 10;
    localparam int binW = 4;
    localparam int countW = 8;
    localparam int acqW = 9;

    // strobes per pass, enough to push one bin past 255
    localparam int acqLen = 320;

    // bin geometry
    // coarse bins are 64 codes wide, fine bins 4
    localparam int coarseShift = 6;
    localparam int fineShift = 2;
    localparam int numBins = 1 << binW;
    localparam int lastBin = numBins - 1;
    // width of one coarse bin, which is also the fine window
    localparam int coarseSpan = 1 << coarseShift;

    // sample codes and window bounds
    typedef logic [sampleW-1:0] sample_t;
    // bin index, also peakCH and peakFH
    typedef logic [binW-1:0] binAddr_t;
    // saturating bin count
    typedef logic [countW-1:0] binCount_t;
    // strobes seen in the current pass
    typedef logic [acqW-1:0] acqCount_t;

    // pass sequencing in the execute stage
    typedef enum logic [1:0] {
        stAcquire,
        stScan,
        stSettle
    } hisState_t;

endpackage

`default_nettype wire

// ==== rtl/binMapper.sv ====
`default_nettype none
`timescale 1ns/10ps

module binMapper (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wrEn,
    input  sifhPkg::sample_t  roughData,
    input  logic              hisNum,
    input  sifhPkg::sample_t  thMinus,
    output logic              binStrobe,
    output sifhPkg::binAddr_t binAddr,
    output logic              binKeep
);
    import sifhPkg::*;

    sample_t  fineOffset;
    binAddr_t coarseBin;
    binAddr_t fineBin;
    logic     inWindow;
    binAddr_t nextBin;
    logic     nextKeep;

    // coarse pass: top bits of the code pick the bin
    assign coarseBin = binAddr_t'(roughData >> coarseShift);

    // fine pass: distance above the window floor
    assign fineOffset = roughData - thMinus;
    // 4 codes per fine bin
    assign fineBin = binAddr_t'(fineOffset >> fineShift);
    // below thMinus wraps the offset, so check both ends
    assign inWindow = (roughData >= thMinus) && (fineOffset < sample_t'(coarseSpan));

    // pick per pass
    assign nextBin = hisNum ? fineBin : coarseBin;
    // every coarse sample counts
    assign nextKeep = hisNum ? inWindow : 1'b1;

    // strobe and keep flag
    always_ff @(posedge clk) begin
        if (!rstN) begin
            binStrobe <= 1'b0;
            binKeep <= 1'b0;
        end else begin
            binStrobe <= wrEn;
            // out-of-window samples still strobe, just not kept
            binKeep <= wrEn & nextKeep;
        end
    end

    // bin address only moves with a new sample
    always_ff @(posedge clk) begin
        if (wrEn) begin
            binAddr <= nextBin;
        end
    end

    // a kept sample is always a strobed one
    // a kept fine sample shares its coarse bin with the window floor
    keepNeedsStrobe: assert property (
        @(posedge clk) disable iff (!rstN)
        binKeep |-> binStrobe && (!$past(hisNum)
            || (($past(roughData) >> coarseShift) == ($past(thMinus) >> coarseShift)))
    );

endmodule

`default_nettype wire

// ==== rtl/hisBuilderFSM.sv ====
`default_nettype none
`timescale 1ns/10ps

module hisBuilderFSM (
    input  logic               clk,
    input  logic               rstN,
    input  logic               binStrobe,
    input  sifhPkg::binAddr_t  binAddr,
    input  logic               binKeep,
    input  logic               peakValid,
    output logic               hisNum,
    output logic               acqCountFinish,
    output logic               resultValid,
    output logic               scanValid,
    output logic               scanLast,
    output sifhPkg::binAddr_t  scanAddr,
    output sifhPkg::binCount_t scanCount
);
    import sifhPkg::*;

    hisState_t state;
    acqCount_t acqCnt;
    binCount_t counts [numBins];
    logic      acqDone;
    logic      binFull;

    // last strobe of the pass
    assign acqDone = binStrobe && (acqCnt == acqCount_t'(acqLen - 1));
    // saturation check on the addressed bin
    assign binFull = (counts[binAddr] == '1);

    // scan read port
    assign scanCount = counts[scanAddr];
    assign scanLast = scanValid && (scanAddr == binAddr_t'(lastBin));

    // bin counters
    // count in acquire, clear each bin as the scan reads it
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numBins; i++) begin
                counts[i] <= '0;
            end
        end else if (state == stAcquire) begin
            // hold at 255
            if (binStrobe && binKeep && !binFull) begin
                counts[binAddr] <= counts[binAddr] + 1'b1;
            end
        end else if (scanValid) begin
            counts[scanAddr] <= '0;
        end
    end

    // pass sequencing
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stAcquire;
            acqCnt <= '0;
            hisNum <= 1'b0;
            acqCountFinish <= 1'b0;
            resultValid <= 1'b0;
            scanValid <= 1'b0;
            scanAddr <= '0;
        end else begin
            // single-cycle pulses
            acqCountFinish <= 1'b0;
            resultValid <= 1'b0;

            case (state)
                stAcquire: begin
                    // every arrival counts toward acqLen, kept or not
                    if (acqDone) begin
                        acqCnt <= '0;
                        acqCountFinish <= 1'b1;
                        scanValid <= 1'b1;
                        scanAddr <= '0;
                        state <= stScan;
                    end else if (binStrobe) begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end

                stScan: begin
                    // strobes here are dropped
                    if (scanLast) begin
                        scanValid <= 1'b0;
                        state <= stSettle;
                    end else begin
                        scanAddr <= scanAddr + 1'b1;
                    end
                end

                stSettle: begin
                    // peak commit lands here
                    // next pass starts with the other geometry
                    if (peakValid) begin
                        hisNum <= ~hisNum;
                        // fine pass done means both peaks ready
                        resultValid <= hisNum;
                        state <= stAcquire;
                    end
                end

                default: begin
                    state <= stAcquire;
                end
            endcase
        end
    end

    // scan window tracks the state register
    scanOnlyInScan: assert property (
        @(posedge clk) disable iff (!rstN)
        scanValid == (state == stScan)
    );

    // a counted hit never leaves its bin at zero
    noCounterWrap: assert property (
        @(posedge clk) disable iff (!rstN)
        (state == stAcquire && binStrobe && binKeep) |=> (counts[$past(binAddr)] != '0)
    );

endmodule

`default_nettype wire

// ==== rtl/peakDetecter.sv ====
`default_nettype none
`timescale 1ns/10ps

module peakDetecter (
    input  logic               clk,
    input  logic               rstN,
    input  logic               scanValid,
    input  logic               scanLast,
    input  sifhPkg::binAddr_t  scanAddr,
    input  sifhPkg::binCount_t scanCount,
    input  logic               hisNum,
    output logic               peakValid,
    output sifhPkg::binAddr_t  peakCH,
    output sifhPkg::binAddr_t  peakFH,
    output sifhPkg::sample_t   thMinus,
    output sifhPkg::sample_t   thPositive
);
    import sifhPkg::*;

    binCount_t runMax;
    binAddr_t  runAddr;
    logic      takeNew;
    binAddr_t  finalAddr;
    sample_t   peakBase;

    // bin 0 restarts the search
    // strictly greater, so ties keep the lower bin
    assign takeNew = (scanAddr == '0) || (scanCount > runMax);

    // includes the bin on the bus this cycle
    assign finalAddr = takeNew ? scanAddr : runAddr;

    // window floor from the coarse peak, 64 codes per bin
    assign peakBase = sample_t'(finalAddr) << coarseShift;

    // running maximum over the scan
    always_ff @(posedge clk) begin
        if (scanValid && takeNew) begin
            runMax <= scanCount;
            runAddr <= scanAddr;
        end
    end

    // peak commit on the last bin
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakValid <= 1'b0;
            peakCH <= '0;
            peakFH <= '0;
            thMinus <= '0;
            thPositive <= '0;
        end else begin
            peakValid <= scanLast;
            if (scanLast) begin
                if (hisNum) begin
                    peakFH <= finalAddr;
                end else begin
                    peakCH <= finalAddr;
                    // fine window is exactly the coarse bin
                    thMinus <= peakBase;
                    thPositive <= peakBase + sample_t'(coarseSpan - 1);
                end
            end
        end
    end

    // one pulse per scan
    peakPulseOnce: assert property (
        @(posedge clk) disable iff (!rstN)
        peakValid |=> !peakValid
    );

endmodule

`default_nettype wire

// ==== rtl/siFhTop.sv ====
`default_nettype none
`timescale 1ns/10ps

module siFhTop (
    input  logic              clk,
    input  logic              rstN,
    input  logic              wrEn,
    input  sifhPkg::sample_t  roughData,
    output logic              hisNum,
    output logic              acqCountFinish,
    output logic              resultValid,
    output sifhPkg::binAddr_t peakCH,
    output sifhPkg::binAddr_t peakFH,
    output sifhPkg::sample_t  thMinus,
    output sifhPkg::sample_t  thPositive
);
    import sifhPkg::*;

    // decode to execute
    logic      binStrobe;
    binAddr_t  binAddr;
    logic      binKeep;

    // execute to result
    logic      scanValid;
    logic      scanLast;
    binAddr_t  scanAddr;
    binCount_t scanCount;

    // result back to execute
    logic      peakValid;

    // sample to bin, windowed in the fine pass
    binMapper binMapper_i (
        .clk       (clk),
        .rstN      (rstN),
        .wrEn      (wrEn),
        .roughData (roughData),
        .hisNum    (hisNum),
        .thMinus   (thMinus),
        .binStrobe (binStrobe),
        .binAddr   (binAddr),
        .binKeep   (binKeep)
    );

    // counters and pass control
    hisBuilderFSM hisBuilderFSM_i (
        .clk            (clk),
        .rstN           (rstN),
        .binStrobe      (binStrobe),
        .binAddr        (binAddr),
        .binKeep        (binKeep),
        .peakValid      (peakValid),
        .hisNum         (hisNum),
        .acqCountFinish (acqCountFinish),
        .resultValid    (resultValid),
        .scanValid      (scanValid),
        .scanLast       (scanLast),
        .scanAddr       (scanAddr),
        .scanCount      (scanCount)
    );

    // peak search and window bounds
    peakDetecter peakDetecter_i (
        .clk        (clk),
        .rstN       (rstN),
        .scanValid  (scanValid),
        .scanLast   (scanLast),
        .scanAddr   (scanAddr),
        .scanCount  (scanCount),
        .hisNum     (hisNum),
        .peakValid  (peakValid),
        .peakCH     (peakCH),
        .peakFH     (peakFH),
        .thMinus    (thMinus),
        .thPositive (thPositive)
    );

endmodule

`default_nettype wire

// ==== include/siFhVectors.svh ====
`ifndef SIFHVECTORS_SVH
`define SIFHVECTORS_SVH

// one stimulus row, a coarse pass then a fine pass
typedef struct packed {
    // coarse samples are base plus random masked by spread
    sifhPkg::sample_t coarseBase;
    sifhPkg::sample_t coarseMask;
    // alternate between base and base plus mask, for an even split
    logic             alternate;
    // fine samples around a chosen code
    sifhPkg::sample_t fineBase;
    sifhPkg::sample_t fineMask;
    // extra strobes while the counters are scanned
    logic             scanStrobes;
    // pull reset part-way through the pass
    logic             midReset;
} vecRow_t;

localparam int numRows = 6;

// coarse base, coarse mask, alternate, fine base, fine mask, scan strobes, mid reset
localparam vecRow_t vecTable [numRows] = '{
    // plain spread inside one coarse bin
    '{10'd300, 10'd15, 1'b0, 10'd300, 10'd3, 1'b0, 1'b0},
    // single code, bin saturates in both passes
    '{10'd517, 10'd0, 1'b0, 10'd517, 10'd0, 1'b0, 1'b0},
    // two bins with equal counts, lower bin wins
    '{10'd128, 10'd64, 1'b1, 10'd132, 10'd4, 1'b0, 1'b0},
    // fine samples mostly above the window
    '{10'd640, 10'd7, 1'b0, 10'd690, 10'd31, 1'b0, 1'b0},
    // strobes during scan are dropped
    '{10'd900, 10'd31, 1'b0, 10'd910, 10'd7, 1'b1, 1'b0},
    // reset mid-pass, then a clean tied run
    '{10'd40, 10'd64, 1'b1, 10'd44, 10'd4, 1'b0, 1'b1}
};

`endif

// ==== tb/siFhTb.sv ====
`default_nettype none
`timescale 1ns/10ps

module siFhTb;
    import sifhPkg::*;

    `include "siFhVectors.svh"

    localparam int clkPeriod = 100;
    localparam int driveDelay = 10;
    localparam int resetCycles = 3;
    // wrEn edge of the last sample to the hisNum toggle
    localparam int passLatency = 19;
    // cycle after the last sample's edge where acqCountFinish is high
    localparam int finishTick = 2;
    localparam int resetPassLen = 60;
    localparam int countMax = (1 << countW) - 1;
    localparam int timeoutCycles = numRows * 2 * (acqLen + 25) + 100;

    logic     clk;
    logic     rstN;
    logic     wrEn;
    sample_t  roughData;
    logic     hisNum;
    logic     acqCountFinish;
    logic     resultValid;
    binAddr_t peakCH;
    binAddr_t peakFH;
    sample_t  thMinus;
    sample_t  thPositive;

    integer seed;
    int     cycleCount;
    // reference histogram of the pass in flight
    int     histModel [numBins];
    int     expPeakC;
    int     expPeakF;
    int     expThMinus;

    siFhTop siFhTop_i (
        .clk            (clk),
        .rstN           (rstN),
        .wrEn           (wrEn),
        .roughData      (roughData),
        .hisNum         (hisNum),
        .acqCountFinish (acqCountFinish),
        .resultValid    (resultValid),
        .peakCH         (peakCH),
        .peakFH         (peakFH),
        .thMinus        (thMinus),
        .thPositive     (thPositive)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // watchdog sized from the table length
    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("test failed");
        $fatal(1, "timeout");
    end

    task automatic reportMismatch(input string name, input int expVal, input int actVal);
        $display("FAIL time=%0t signal=%s expected=%0d actual=%0d",
                 $time, name, expVal, actVal);
        $display("test failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    // inputs change a little after the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #driveDelay;
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        wrEn = 1'b0;
        repeat (resetCycles) nextCycle();
        rstN = 1'b1;
    endtask

    task automatic expectResetState();
        assert (hisNum == 1'b0) else reportMismatch("hisNum", 0, int'(hisNum));
        assert (acqCountFinish == 1'b0)
            else reportMismatch("acqCountFinish", 0, int'(acqCountFinish));
        assert (resultValid == 1'b0) else reportMismatch("resultValid", 0, int'(resultValid));
        assert (peakCH == '0) else reportMismatch("peakCH", 0, int'(peakCH));
        assert (peakFH == '0) else reportMismatch("peakFH", 0, int'(peakFH));
        assert (thMinus == '0) else reportMismatch("thMinus", 0, int'(thMinus));
        assert (thPositive == '0) else reportMismatch("thPositive", 0, int'(thPositive));
    endtask

    // base plus masked random, or an even two-way split
    function automatic sample_t makeSample(input sample_t base, input sample_t mask,
                                           input logic alt, input int idx);
        integer         r;
        sample_t        offset;
        logic [sampleW:0] sum;
        r = $random(seed);
        if (alt) begin
            offset = idx[0] ? mask : '0;
        end else begin
            offset = sample_t'(r) & mask;
        end
        sum = {1'b0, base} + {1'b0, offset};
        // clamp at the top code
        if (sum > {1'b0, {sampleW{1'b1}}}) begin
            return '1;
        end
        return sample_t'(sum);
    endfunction

    // 64 codes per coarse bin
    function automatic int coarseBinOf(input sample_t code);
        return int'(code) >> coarseShift;
    endfunction

    // -1 when outside the window
    function automatic int fineBinOf(input sample_t code, input int lo);
        int off;
        off = int'(code) - lo;
        if (off < 0 || off >= coarseSpan) begin
            return -1;
        end
        return off >> fineShift;
    endfunction

    task automatic countSample(input int b);
        // saturate at 255
        if (b >= 0 && histModel[b] < countMax) begin
            histModel[b] = histModel[b] + 1;
        end
    endtask

    // strictly greater wins, so ties stay on the lower bin
    function automatic int modelPeak();
        int best;
        best = 0;
        for (int i = 1; i < numBins; i++) begin
            if (histModel[i] > histModel[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    // one strobe per cycle, the first one on the current cycle
    task automatic sendSamples(input logic fine, input vecRow_t row, input int count);
        sample_t code;
        for (int i = 0; i < numBins; i++) begin
            histModel[i] = 0;
        end
        for (int i = 0; i < count; i++) begin
            if (i > 0) begin
                nextCycle();
                assert (resultValid == 1'b0)
                    else reportMismatch("resultValid", 0, int'(resultValid));
            end
            assert (acqCountFinish == 1'b0)
                else reportMismatch("acqCountFinish", 0, int'(acqCountFinish));
            assert (hisNum == fine) else reportMismatch("hisNum", int'(fine), int'(hisNum));
            if (fine) begin
                code = makeSample(row.fineBase, row.fineMask, row.alternate, i);
                countSample(fineBinOf(code, expThMinus));
            end else begin
                code = makeSample(row.coarseBase, row.coarseMask, row.alternate, i);
                countSample(coarseBinOf(code));
            end
            wrEn = 1'b1;
            roughData = code;
        end
    endtask

    // scan and settle, counted from the last sample's drive edge
    task automatic awaitToggle(input logic fine, input logic scanStrobes);
        int   n;
        logic startNum;
        startNum = hisNum;
        n = 0;
        while (hisNum == startNum) begin
            nextCycle();
            n++;
            wrEn = 1'b0;
            // these land in scan and must be dropped
            if (scanStrobes && n >= 2 && n <= 16) begin
                wrEn = 1'b1;
                roughData = sample_t'($random(seed));
            end
            assert (acqCountFinish == (n == finishTick))
                else reportMismatch("acqCountFinish", int'(n == finishTick),
                                    int'(acqCountFinish));
            if (hisNum == startNum) begin
                assert (resultValid == 1'b0)
                    else reportMismatch("resultValid", 0, int'(resultValid));
            end
        end
        assert (n == passLatency) else reportMismatch("hisNum toggle delay", passLatency, n);
        // only the fine-to-coarse toggle carries resultValid
        assert (resultValid == fine)
            else reportMismatch("resultValid", int'(fine), int'(resultValid));
    endtask

    task automatic compareResults(input logic fine);
        assert (int'(peakCH) == expPeakC) else reportMismatch("peakCH", expPeakC, int'(peakCH));
        assert (int'(thMinus) == expThMinus)
            else reportMismatch("thMinus", expThMinus, int'(thMinus));
        assert (int'(thPositive) == expThMinus + coarseSpan - 1)
            else reportMismatch("thPositive", expThMinus + coarseSpan - 1, int'(thPositive));
        if (fine) begin
            assert (int'(peakFH) == expPeakF)
                else reportMismatch("peakFH", expPeakF, int'(peakFH));
        end
    endtask

    task automatic runRow(input vecRow_t row);
        sendSamples(1'b0, row, acqLen);
        awaitToggle(1'b0, row.scanStrobes);
        // window comes from the model's own coarse peak
        expPeakC = modelPeak();
        expThMinus = expPeakC * coarseSpan;
        compareResults(1'b0);
        sendSamples(1'b1, row, acqLen);
        awaitToggle(1'b1, row.scanStrobes);
        expPeakF = modelPeak();
        compareResults(1'b1);
    endtask

    initial begin
        vecRow_t partRow;
        seed = 32'h4bde_ba6c;
        rstN = 1'b0;
        wrEn = 1'b0;
        roughData = '0;
        applyReset();
        expectResetState();
        for (int r = 0; r < numRows; r++) begin
            if (vecTable[r].midReset) begin
                // partial coarse pass on the upper code only, then reset
                // leftover counts there would break the tie of the full run
                partRow = vecTable[r];
                partRow.coarseBase = vecTable[r].coarseBase + vecTable[r].coarseMask;
                partRow.coarseMask = '0;
                partRow.alternate = 1'b0;
                sendSamples(1'b0, partRow, resetPassLen);
                applyReset();
                expectResetState();
            end
            runRow(vecTable[r]);
        end
        nextCycle();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== siFh.f ====
+incdir+include
rtl/sifhPkg.sv
rtl/binMapper.sv
rtl/hisBuilderFSM.sv
rtl/peakDetecter.sv
rtl/siFhTop.sv
tb/siFhTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the siFh testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module siFhTb -f siFh.f -o siFhSim

./obj_dir/siFhSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^test passed$" sim.log; then
    echo "simulation: PASS"
else
    echo "simulation: FAIL"
    exit 1
fi
